/* source/priv_unit_params.svh */
// Build-time constants for the machine-mode privilege unit
// Only PRIV_XLEN = 32 is supported; the CSR layouts assume RV32
// The misa mask uses the standard letter bits (A = bit 0)

`ifndef PRIV_UNIT_PARAMS_SVH
`define PRIV_UNIT_PARAMS_SVH

// Data path width
`define PRIV_XLEN 32

// Value returned by mhartid
`define PRIV_HARTID 32'd0

// misa extension field
// I is bit 8 and M is bit 12
`define PRIV_MISA_EXT 26'h000_1100

`endif

/* source/priv_unit_pkg.sv */
// Types shared by the privilege unit: CSR addresses, register layouts,
// and the structs that travel between the CSR file and the trap FSM.
// Only M and U privilege exist; S-mode fields are hard zero.

`default_nettype none

`include "priv_unit_params.svh"

package priv_unit_pkg;

  // Bits 9:8 give the lowest privilege and bits 11:10 = 11 mean read-only
  typedef enum logic [11:0] {
    MVENDORID_ADDR = 12'hF11, MARCHID_ADDR = 12'hF12, MIMPID_ADDR = 12'hF13,
    MHARTID_ADDR = 12'hF14, MCONFIGPTR_ADDR = 12'hF15,
    MSTATUS_ADDR = 12'h300, MISA_ADDR = 12'h301, MIE_ADDR = 12'h304,
    MTVEC_ADDR = 12'h305, MCOUNTEREN_ADDR = 12'h306, MSTATUSH_ADDR = 12'h310,
    MCOUNTINHIBIT_ADDR = 12'h320,
    MSCRATCH_ADDR = 12'h340, MEPC_ADDR = 12'h341, MCAUSE_ADDR = 12'h342,
    MTVAL_ADDR = 12'h343, MIP_ADDR = 12'h344,
    MCYCLE_ADDR = 12'hB00, MINSTRET_ADDR = 12'hB02,
    MCYCLEH_ADDR = 12'hB80, MINSTRETH_ADDR = 12'hB82
  } csr_addr_t;

  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    M_MODE = 2'b11
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'b00,
    VECTORED = 2'b01
  } mtvec_mode_t;

  typedef struct packed {
    logic [18:0] zero_hi;   // sd, tsr, tw, mprv, fs, xs... all zero
    logic [1:0]  mpp;
    logic [2:0]  zero_vs_spp;
    logic        mpie;
    logic [2:0]  zero_ube_spie;
    logic        mie;
    logic [2:0]  zero_sie;
  } mstatus_t;

  typedef struct packed {
    logic [29:0] base;
    mtvec_mode_t mode;
  } mtvec_t;

  typedef struct packed {
    logic [19:0] zero_hi;
    logic        meie;
    logic [2:0]  zero_seie;
    logic        mtie;
    logic [2:0]  zero_stie;
    logic        msie;
    logic [2:0]  zero_ssie;
  } mie_t;

  typedef struct packed {
    logic [19:0] zero_hi;
    logic        meip;
    logic [2:0]  zero_seip;
    logic        mtip;
    logic [2:0]  zero_stip;
    logic        msip;
    logic [2:0]  zero_ssip;
  } mip_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  typedef struct packed {
    logic [28:0] zero_hpm;
    logic        ir;
    logic        zero_tm;
    logic        cy;
  } counter_inhibit_t;

  typedef struct packed {
    logic                  mod;     // Write strobe (rdata is always the old value)
    csr_addr_t             addr;
    logic [`PRIV_XLEN-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic                  valid;
    logic [30:0]           cause;
    logic [`PRIV_XLEN-1:0] epc;
    logic [`PRIV_XLEN-1:0] tval;
  } trap_req_t;

  typedef struct packed {
    logic                  save;     // Trap entry write
    logic                  restore;  // mret write
    mcause_t               cause;
    logic [`PRIV_XLEN-1:0] epc;
    logic [`PRIV_XLEN-1:0] tval;
    priv_level_t           prev_priv;
  } trap_update_t;

  typedef struct packed {
    logic                  mie;
    logic                  mpie;
    logic [1:0]            mpp;
    mtvec_t                mtvec;
    logic [`PRIV_XLEN-1:0] mepc;
    mip_t                  pending;  // mip & mie
  } csr_state_t;

  // Interrupt cause codes
  localparam logic [30:0] IRQ_M_SOFT  = 31'd3;
  localparam logic [30:0] IRQ_M_TIMER = 31'd7;
  localparam logic [30:0] IRQ_M_EXT   = 31'd11;

  // Exception cause codes
  localparam logic [30:0] EXC_INSN_MISALIGNED  = 31'd0;
  localparam logic [30:0] EXC_INSN_FAULT       = 31'd1;
  localparam logic [30:0] EXC_ILLEGAL_INSN     = 31'd2;
  localparam logic [30:0] EXC_BREAKPOINT       = 31'd3;
  localparam logic [30:0] EXC_LOAD_MISALIGNED  = 31'd4;
  localparam logic [30:0] EXC_LOAD_FAULT       = 31'd5;
  localparam logic [30:0] EXC_STORE_MISALIGNED = 31'd6;
  localparam logic [30:0] EXC_STORE_FAULT      = 31'd7;
  localparam logic [30:0] EXC_ECALL_U          = 31'd8;
  localparam logic [30:0] EXC_ECALL_M          = 31'd11;

  // Reset values
  localparam mstatus_t         MSTATUS_RESET       = '{mpp: 2'b11, default: '0};
  localparam mtvec_t           MTVEC_RESET         = '0;
  localparam counter_inhibit_t MCOUNTINHIBIT_RESET = '1;
  localparam logic [1:0]       MISA_MXL_RV32       = 2'd1;

endpackage

`default_nettype wire

/* source/priv_perf_counters.sv */
// 64-bit mcycle and minstret counters
// inst_ret counts at most one retired instruction per cycle
// Counters reset to zero and cannot be written by software

`timescale 1ns/1ps
`default_nettype none

module priv_perf_counters
  import priv_unit_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  counter_inhibit_t inhibit,
  input  logic             inst_ret,
  output logic [63:0]      cycles,
  output logic [63:0]      instret
);

  logic [63:0] cycles_next;
  logic [63:0] instret_next;

  always_comb begin
    cycles_next  = cycles;
    instret_next = instret;
    if (!inhibit.cy) cycles_next = cycles + 64'd1;
    if (!inhibit.ir) instret_next = instret + {63'd0, inst_ret};
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycles  <= '0;
      instret <= '0;
    end else begin
      cycles  <= cycles_next;
      instret <= instret_next;
    end
  end

endmodule

`default_nettype wire

/* source/priv_csr_file.sv */
// Machine CSR storage with access check and write legalization
// An all-zero csr request is treated as an idle bus and never flags invalid
// Trap entry and mret updates win over a software write in the same cycle

`timescale 1ns/1ps
`default_nettype none

`include "priv_unit_params.svh"

module priv_csr_file
  import priv_unit_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  csr_req_t              csr,
  input  priv_level_t           curr_priv,
  input  trap_update_t          upd,
  input  logic                  irq_ext,
  input  logic                  irq_timer,
  input  logic                  irq_soft,
  input  logic [63:0]           cycles,
  input  logic [63:0]           instret,
  output logic [`PRIV_XLEN-1:0] rdata,
  output logic                  invalid,
  output csr_state_t            state,
  output counter_inhibit_t      inhibit
);

  mstatus_t              mstatus;
  mtvec_t                mtvec;
  mie_t                  mie;
  mip_t                  mip;
  mcause_t               mcause;
  counter_inhibit_t      mcountinhibit;
  logic [`PRIV_XLEN-1:0] mscratch;
  logic [`PRIV_XLEN-1:0] mepc;
  logic [`PRIV_XLEN-1:0] mtval;
  logic [`PRIV_XLEN-1:0] mcounteren;

  logic [`PRIV_XLEN-1:0] csr_val;   // Unmasked read value
  logic [`PRIV_XLEN-1:0] wval;      // Legalized write value
  logic                  csr_known;
  logic                  csr_idle;
  logic                  wr_en;

  assign csr_idle = (csr == '0);

  // Read mux that also flags unknown addresses
  always_comb begin
    csr_val   = '0;
    csr_known = 1'b1;
    case (csr.addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR,
      MCONFIGPTR_ADDR, MSTATUSH_ADDR: csr_val = '0;
      MHARTID_ADDR:       csr_val = `PRIV_HARTID;
      MISA_ADDR:          csr_val = {MISA_MXL_RV32, 4'b0000, `PRIV_MISA_EXT};
      MSTATUS_ADDR:       csr_val = mstatus;
      MIE_ADDR:           csr_val = mie;
      MTVEC_ADDR:         csr_val = mtvec;
      MCOUNTEREN_ADDR:    csr_val = mcounteren;
      MCOUNTINHIBIT_ADDR: csr_val = mcountinhibit;
      MSCRATCH_ADDR:      csr_val = mscratch;
      MEPC_ADDR:          csr_val = mepc;
      MCAUSE_ADDR:        csr_val = mcause;
      MTVAL_ADDR:         csr_val = mtval;
      MIP_ADDR:           csr_val = mip;
      MCYCLE_ADDR:        csr_val = cycles[31:0];
      MCYCLEH_ADDR:       csr_val = cycles[63:32];
      MINSTRET_ADDR:      csr_val = instret[31:0];
      MINSTRETH_ADDR:     csr_val = instret[63:32];
      default:            csr_known = 1'b0;
    endcase
  end

  // Privilege, existence and read-only checks
  always_comb begin
    invalid = 1'b0;
    if (!csr_idle) begin
      if (!csr_known || (csr.addr[9:8] > curr_priv)) begin
        invalid = 1'b1;
      end else if (csr.mod && (csr.addr[11:10] == 2'b11)) begin
        invalid = 1'b1;             // Write to a read-only CSR
      end
    end
  end

  assign rdata = invalid ? '0 : csr_val;
  assign wr_en = csr.mod && !invalid;

  // WARL fixups
  always_comb begin
    wval = csr.wdata;
    if ((csr.addr == MSTATUS_ADDR) && (csr.wdata[12:11] == 2'b10)) begin
      wval[12:11] = 2'b00;          // Reserved mpp encoding
    end
    if ((csr.addr == MTVEC_ADDR) && (csr.wdata[1:0] > 2'b01)) begin
      wval[1:0] = 2'b00;            // Fall back to direct mode
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= MSTATUS_RESET;
      mtvec         <= MTVEC_RESET;
      mie           <= '0;
      mip           <= '0;
      mcause        <= '0;
      mcountinhibit <= MCOUNTINHIBIT_RESET;
      mscratch      <= '0;
      mepc          <= '0;
      mtval         <= '0;
      mcounteren    <= '0;
    end else begin
      // Pins sampled every edge
      mip.meip <= irq_ext;
      mip.mtip <= irq_timer;
      mip.msip <= irq_soft;

      if (wr_en) begin
        case (csr.addr)
          MSTATUS_ADDR: begin
            mstatus.mie  <= wval[3];
            mstatus.mpie <= wval[7];
            mstatus.mpp  <= wval[12:11];
          end
          MIE_ADDR: begin
            mie.msie <= wval[3];
            mie.mtie <= wval[7];
            mie.meie <= wval[11];
          end
          MTVEC_ADDR:      mtvec      <= mtvec_t'(wval);
          MCOUNTEREN_ADDR: mcounteren <= wval;
          MCOUNTINHIBIT_ADDR: begin
            mcountinhibit.cy <= wval[0];
            mcountinhibit.ir <= wval[2];
          end
          MSCRATCH_ADDR:   mscratch   <= wval;
          MEPC_ADDR:       mepc       <= wval;
          MCAUSE_ADDR:     mcause     <= mcause_t'(wval);
          MTVAL_ADDR:      mtval      <= wval;
          default: ;                 // Constants and counters ignore writes
        endcase
      end

      // Later assignments override the software write
      if (upd.save) begin
        mepc         <= upd.epc;
        mcause       <= upd.cause;
        mtval        <= upd.tval;
        mstatus.mpie <= mstatus.mie;
        mstatus.mie  <= 1'b0;
        mstatus.mpp  <= upd.prev_priv;
      end else if (upd.restore) begin
        mstatus.mie  <= mstatus.mpie;
        mstatus.mpie <= 1'b1;
        mstatus.mpp  <= U_MODE;
      end
    end
  end

  assign state.mie     = mstatus.mie;
  assign state.mpie    = mstatus.mpie;
  assign state.mpp     = mstatus.mpp;
  assign state.mtvec   = mtvec;
  assign state.mepc    = mepc;
  assign state.pending = mip_t'(mip & mie);

  assign inhibit = mcountinhibit;

endmodule

`default_nettype wire

/* source/priv_trap_fsm.sv */
// Trap entry and mret sequencing, current privilege and redirect target
// Events arriving while the FSM is busy are dropped, not queued
// Priority is exception, then interrupt (ext, soft, timer), then mret

`timescale 1ns/1ps
`default_nettype none

`include "priv_unit_params.svh"

module priv_trap_fsm
  import priv_unit_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  trap_req_t             trap,
  input  logic                  mret,
  input  csr_state_t            state,
  output trap_update_t          upd,
  output priv_level_t           priv,
  output logic                  insert_pc,
  output logic [`PRIV_XLEN-1:0] priv_pc
);

  typedef enum logic [1:0] {
    IDLE,
    SAVE,
    RESTORE,
    REDIRECT
  } fsm_t;

  fsm_t                  fsm_q;
  logic                  is_mret_q;   // Redirect goes to mepc
  mcause_t               cause_q;
  logic [`PRIV_XLEN-1:0] epc_q;
  logic [`PRIV_XLEN-1:0] tval_q;

  logic                  irq_take;
  logic [30:0]           irq_code;
  logic [`PRIV_XLEN-1:0] tvec_base;

  // Global enable is implied in U-mode
  assign irq_take = (|state.pending) && (state.mie || (priv == U_MODE));

  always_comb begin
    if (state.pending.meip) irq_code = IRQ_M_EXT;
    else if (state.pending.msip) irq_code = IRQ_M_SOFT;
    else irq_code = IRQ_M_TIMER;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fsm_q     <= IDLE;
      priv      <= M_MODE;
      is_mret_q <= 1'b0;
    end else begin
      case (fsm_q)
        IDLE: begin
          if (trap.valid || irq_take) begin
            fsm_q     <= SAVE;
            is_mret_q <= 1'b0;
          end else if (mret) begin
            fsm_q     <= RESTORE;
            is_mret_q <= 1'b1;
          end
        end
        SAVE: begin
          priv  <= M_MODE;
          fsm_q <= REDIRECT;
        end
        RESTORE: begin
          priv  <= priv_level_t'(state.mpp);
          fsm_q <= REDIRECT;
        end
        default: fsm_q <= IDLE;     // REDIRECT lasts one cycle
      endcase
    end
  end

  // Trap payload is captured on entry only
  always_ff @(posedge CLK) begin
    if ((fsm_q == IDLE) && trap.valid) begin
      cause_q <= '{interrupt: 1'b0, code: trap.cause};
      epc_q   <= trap.epc;
      tval_q  <= trap.tval;
    end else if ((fsm_q == IDLE) && irq_take) begin
      cause_q <= '{interrupt: 1'b1, code: irq_code};
      epc_q   <= trap.epc;
      tval_q  <= '0;
    end
  end

  assign upd.save      = (fsm_q == SAVE);
  assign upd.restore   = (fsm_q == RESTORE);
  assign upd.cause     = cause_q;
  assign upd.epc       = epc_q;
  assign upd.tval      = tval_q;
  assign upd.prev_priv = priv;  // Still the old level during SAVE

  assign insert_pc = (fsm_q == REDIRECT);
  assign tvec_base = {state.mtvec.base, 2'b00};

  always_comb begin
    if (is_mret_q) begin
      priv_pc = state.mepc;
    end else if (cause_q.interrupt && (state.mtvec.mode == VECTORED)) begin
      priv_pc = tvec_base + {cause_q.code[29:0], 2'b00};
    end else begin
      priv_pc = tvec_base;
    end
  end

endmodule

`default_nettype wire

/* source/priv_unit_top.sv */
// Machine-mode privilege unit for an RV32 core (M and U only)
// No handshake: the pipeline must hold off traps and mret until insert_pc
// CSR rdata and invalid are combinational from csr

`timescale 1ns/1ps
`default_nettype none

`include "priv_unit_params.svh"

module priv_unit_top
  import priv_unit_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  csr_req_t              csr,
  input  trap_req_t             trap,
  input  logic                  mret,
  input  logic                  inst_ret,
  input  logic                  irq_ext,
  input  logic                  irq_timer,
  input  logic                  irq_soft,
  output logic [`PRIV_XLEN-1:0] rdata,
  output logic                  invalid,
  output priv_level_t           priv,
  output logic                  insert_pc,
  output logic [`PRIV_XLEN-1:0] priv_pc
);

  csr_state_t       csr_state;
  trap_update_t     upd;
  counter_inhibit_t inhibit;
  logic [63:0]      cycles;
  logic [63:0]      instret;

  priv_csr_file u_csr_file (
    .CLK       (CLK),
    .nRST      (nRST),
    .csr       (csr),
    .curr_priv (priv),
    .upd       (upd),
    .irq_ext   (irq_ext),
    .irq_timer (irq_timer),
    .irq_soft  (irq_soft),
    .cycles    (cycles),
    .instret   (instret),
    .rdata     (rdata),
    .invalid   (invalid),
    .state     (csr_state),
    .inhibit   (inhibit)
  );

  priv_perf_counters u_counters (
    .CLK      (CLK),
    .nRST     (nRST),
    .inhibit  (inhibit),
    .inst_ret (inst_ret),
    .cycles   (cycles),
    .instret  (instret)
  );

  priv_trap_fsm u_trap_fsm (
    .CLK       (CLK),
    .nRST      (nRST),
    .trap      (trap),
    .mret      (mret),
    .state     (csr_state),
    .upd       (upd),
    .priv      (priv),
    .insert_pc (insert_pc),
    .priv_pc   (priv_pc)
  );

endmodule

`default_nettype wire

/* verif/priv_unit_tb_tasks.svh */
// Compare and drive tasks, included inside priv_unit_tb
// Drive tasks start 1 ns after a rising edge and return with the inputs idle
// The pipeline side holds off new events until insert_pc, as the DUT expects

task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
  checks++;
  if (act !== exp) begin
    errors++;
    test_errs++;
    $display("ERR %s %s: expected %h, got %h", test_name, what, exp, act);
  end
endtask

task automatic check_priv(input string what, input priv_level_t exp, input priv_level_t act);
  checks++;
  if (act !== exp) begin
    errors++;
    test_errs++;
    $display("ERR %s %s: expected %h, got %h", test_name, what, exp, act);
  end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
  checks++;
  if (act !== exp) begin
    errors++;
    test_errs++;
    $display("ERR %s %s: expected %b, got %b", test_name, what, exp, act);
  end
endtask

task automatic report_failure(input string msg);
  errors++;
  test_errs++;
  $display("%s: %s", test_name, msg);
endtask

// One CSR access whose expected old value is queued for the checker
task automatic csr_access(input logic mod, input logic [11:0] addr, input logic [31:0] wdata);
  logic fault;
  @(posedge CLK);
  #1;
  fault = access_fault(addr, mod, ref_priv);
  csr = '{mod: mod, addr: csr_addr_t'(addr), wdata: wdata};
  exp_name.push_back($sformatf("%s %h", mod ? "write" : "read", addr));
  exp_rdata.push_back(fault ? 32'd0 : ref_csr[addr]);
  exp_inv.push_back(fault);
  if (mod && !fault) begin
    ref_csr[addr] = legal_value(addr, ref_csr[addr], wdata);
  end
  @(posedge CLK);
  #1;
  csr = '0;
endtask

// Counter read that returns value and cycle for delta checks
task automatic read_counter(input logic [11:0] addr, output logic [31:0] value,
                            output int at_cycle);
  @(posedge CLK);
  #1;
  csr = '{mod: 1'b0, addr: csr_addr_t'(addr), wdata: 32'd0};
  at_cycle = cycle_cnt;
  @(negedge CLK);
  value = rdata;
  @(posedge CLK);
  #1;
  csr = '0;
endtask

task automatic raise_trap(input logic [30:0] cause, input logic [31:0] epc,
                          input logic [31:0] tval);
  @(posedge CLK);
  #1;
  trap = '{valid: 1'b1, cause: cause, epc: epc, tval: tval};
  event_cycle = cycle_cnt;
  @(posedge CLK);
  #1;
  trap = '0;               // Also clears epc for later interrupts
endtask

task automatic issue_mret();
  @(posedge CLK);
  #1;
  mret = 1'b1;
  event_cycle = cycle_cnt;
  @(posedge CLK);
  #1;
  mret = 1'b0;
endtask

// Latency 0 skips the cycle count (interrupt pins go through mip first)
task automatic await_redirect(input string what, input int latency);
  int waited;
  waited = 0;
  while (!redirect_seen && waited < 10) begin
    @(posedge CLK);
    waited++;
  end
  if (!redirect_seen) begin
    report_failure({"no insert_pc within 10 cycles after ", what});
    want_redirect = 1'b0;
  end else if (latency > 0) begin
    check_word({what, " latency"}, latency, redirect_cycle - event_cycle);
  end
  #1;
endtask

/* verif/priv_unit_tb.sv */
// Testbench for priv_unit_top (M and U privilege, RV32 CSRs)
// A CSR model keyed by address predicts reads, and traps update it after insert_pc
// Counter values are checked as deltas between two reads

`timescale 1ns/1ps
`default_nettype none

`include "priv_unit_params.svh"

module priv_unit_tb
  import priv_unit_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 3000;

  localparam logic [11:0] CSR_LIST [21] = '{
    MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MHARTID_ADDR, MCONFIGPTR_ADDR,
    MSTATUS_ADDR, MISA_ADDR, MIE_ADDR, MTVEC_ADDR, MCOUNTEREN_ADDR, MSTATUSH_ADDR,
    MCOUNTINHIBIT_ADDR, MSCRATCH_ADDR, MEPC_ADDR, MCAUSE_ADDR, MTVAL_ADDR, MIP_ADDR,
    MCYCLE_ADDR, MINSTRET_ADDR, MCYCLEH_ADDR, MINSTRETH_ADDR
  };
  localparam logic [11:0] RW_LIST [9] = '{
    MSTATUS_ADDR, MIE_ADDR, MTVEC_ADDR, MCOUNTEREN_ADDR, MCOUNTINHIBIT_ADDR,
    MSCRATCH_ADDR, MEPC_ADDR, MCAUSE_ADDR, MTVAL_ADDR
  };
  localparam logic [11:0] RO_LIST [5] = '{
    MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MHARTID_ADDR, MCONFIGPTR_ADDR
  };

  logic        CLK;
  logic        nRST;
  csr_req_t    csr;
  trap_req_t   trap;
  logic        mret;
  logic        inst_ret;
  logic        irq_ext;
  logic        irq_timer;
  logic        irq_soft;
  logic [31:0] rdata;
  logic        invalid;
  priv_level_t priv;
  logic        insert_pc;
  logic [31:0] priv_pc;

  int          errors = 0;
  int          checks = 0;
  int          test_errs = 0;
  int          cycle_cnt = 0;
  int          event_cycle = 0;
  int          redirect_cycle = 0;
  string       test_name = "setup";

  logic [31:0] ref_csr [logic [11:0]];  // Expected CSR contents
  priv_level_t ref_priv;
  string       exp_name [$];
  logic [31:0] exp_rdata [$];
  logic        exp_inv [$];
  logic        want_redirect = 1'b0;
  logic        redirect_seen = 1'b0;
  logic [31:0] exp_pc;
  priv_level_t exp_lvl;

  priv_unit_top u_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .csr       (csr),
    .trap      (trap),
    .mret      (mret),
    .inst_ret  (inst_ret),
    .irq_ext   (irq_ext),
    .irq_timer (irq_timer),
    .irq_soft  (irq_soft),
    .rdata     (rdata),
    .invalid   (invalid),
    .priv      (priv),
    .insert_pc (insert_pc),
    .priv_pc   (priv_pc)
  );

  // Value a CSR holds after a legal write
  function automatic logic [31:0] legal_value(input logic [11:0] addr, input logic [31:0] old,
                                              input logic [31:0] wdata);
    logic [31:0] mask;
    logic [31:0] val;
    case (addr)
      MSTATUS_ADDR:       mask = 32'h0000_1888;  // mie, mpie, mpp
      MIE_ADDR:           mask = 32'h0000_0888;
      MCOUNTINHIBIT_ADDR: mask = 32'h0000_0005;  // cy and ir
      MTVEC_ADDR, MCOUNTEREN_ADDR, MSCRATCH_ADDR,
      MEPC_ADDR, MCAUSE_ADDR, MTVAL_ADDR: mask = '1;
      default:            mask = '0;
    endcase
    val = (old & ~mask) | (wdata & mask);
    if ((addr == MSTATUS_ADDR) && (val[12:11] == 2'b10)) val[12:11] = 2'b00;
    if ((addr == MTVEC_ADDR) && (val[1:0] > 2'b01)) val[1:0] = 2'b00;
    return val;
  endfunction

  function automatic logic access_fault(input logic [11:0] addr, input logic mod,
                                        input priv_level_t lvl);
    return !ref_csr.exists(addr) || (addr[9:8] > lvl) || (mod && (addr[11:10] == 2'b11));
  endfunction

  function automatic void model_trap(input logic [31:0] cause, input logic [31:0] epc,
                                     input logic [31:0] tval);
    logic [31:0] st;
    st = ref_csr[MSTATUS_ADDR];
    st[7] = st[3];
    st[3] = 1'b0;
    st[12:11] = ref_priv;
    ref_csr[MSTATUS_ADDR] = st;
    ref_csr[MEPC_ADDR] = epc;
    ref_csr[MCAUSE_ADDR] = cause;
    ref_csr[MTVAL_ADDR] = tval;
    ref_priv = M_MODE;
  endfunction

  function automatic void model_mret();
    logic [31:0] st;
    st = ref_csr[MSTATUS_ADDR];
    ref_priv = priv_level_t'(st[12:11]);
    st[3] = st[7];
    st[7] = 1'b1;
    st[12:11] = 2'b00;
    ref_csr[MSTATUS_ADDR] = st;
  endfunction

  function automatic void expect_redirect(input logic [31:0] pc, input priv_level_t lvl);
    exp_pc = pc;
    exp_lvl = lvl;
    redirect_seen = 1'b0;
    want_redirect = 1'b1;
  endfunction

  `include "priv_unit_tb_tasks.svh"

  function automatic void start_test(input string name);
    test_name = name;
    test_errs = 0;
  endfunction

  function automatic void end_test();
    $display("%-20s done, %0d errors", test_name, test_errs);
  endfunction

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run stopped: %0d cycles passed before the tests ended", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  // Checker samples at the falling edge where outputs are settled
  initial begin : compare_outputs
    string what;
    forever begin
      @(negedge CLK);
      if (exp_name.size() > 0) begin
        what = exp_name.pop_front();
        check_word(what, exp_rdata.pop_front(), rdata);
        check_flag({what, " invalid"}, exp_inv.pop_front(), invalid);
      end
      if (nRST && insert_pc) begin
        if (want_redirect) begin
          check_word("priv_pc", exp_pc, priv_pc);
          check_priv("priv at redirect", exp_lvl, priv);
          want_redirect = 1'b0;
          redirect_seen = 1'b1;
          redirect_cycle = cycle_cnt;
        end else begin
          report_failure("insert_pc rose with no trap or mret in flight");
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] c1;
    logic [31:0] c2;
    logic [31:0] base;
    int          t1;
    int          t2;
    int          n_ret;
    void'($urandom(32'h896c));
    nRST = 1'b0;
    csr = '0;
    trap = '0;
    mret = 1'b0;
    inst_ret = 1'b0;
    irq_ext = 1'b0;
    irq_timer = 1'b0;
    irq_soft = 1'b0;
    foreach (CSR_LIST[i]) ref_csr[CSR_LIST[i]] = 32'd0;
    ref_csr[MISA_ADDR] = {2'b01, 4'b0000, `PRIV_MISA_EXT};  // MXL = 1 for RV32
    ref_csr[MHARTID_ADDR] = `PRIV_HARTID;
    ref_csr[MSTATUS_ADDR] = 32'h0000_1800;
    ref_csr[MCOUNTINHIBIT_ADDR] = '1;
    ref_priv = M_MODE;
    repeat (5) @(posedge CLK);
    #1;
    nRST = 1'b1;

    start_test("reset values");
    check_priv("priv", M_MODE, priv);
    check_flag("insert_pc", 1'b0, insert_pc);
    check_flag("idle invalid", 1'b0, invalid);
    csr_access(1'b0, MISA_ADDR, 32'd0);
    csr_access(1'b0, MHARTID_ADDR, 32'd0);
    csr_access(1'b0, MSTATUS_ADDR, 32'd0);
    csr_access(1'b0, MTVEC_ADDR, 32'd0);
    csr_access(1'b0, MCOUNTINHIBIT_ADDR, 32'd0);
    end_test();

    start_test("csr round trip");
    for (int r = 0; r < 3; r++) begin
      foreach (RW_LIST[i]) begin
        csr_access(1'b1, RW_LIST[i], $urandom());
        csr_access(1'b0, RW_LIST[i], 32'd0);
      end
    end
    csr_access(1'b1, MSTATUS_ADDR, 32'h0000_1088);  // Reserved mpp
    csr_access(1'b0, MSTATUS_ADDR, 32'd0);
    csr_access(1'b1, MTVEC_ADDR, 32'h0000_0403);    // Reserved mode
    csr_access(1'b0, MTVEC_ADDR, 32'd0);
    foreach (RO_LIST[i]) begin
      csr_access(1'b1, RO_LIST[i], $urandom());
      csr_access(1'b0, RO_LIST[i], 32'd0);
    end
    csr_access(1'b1, 12'h7C0, $urandom());
    csr_access(1'b0, 12'h7C0, 32'd0);
    csr_access(1'b1, 12'h3A0, $urandom());
    csr_access(1'b0, 12'h3A0, 32'd0);
    csr_access(1'b1, MISA_ADDR, $urandom());
    csr_access(1'b0, MISA_ADDR, 32'd0);
    end_test();

    start_test("exception entry");
    csr_access(1'b1, MSTATUS_ADDR, 32'h0000_1808);
    csr_access(1'b1, MTVEC_ADDR, 32'h0000_0100);
    expect_redirect(ref_csr[MTVEC_ADDR] & ~32'h3, M_MODE);
    raise_trap(EXC_ECALL_M, 32'h1000_0040, 32'hDEAD_0001);
    await_redirect("ecall", 2);
    model_trap({1'b0, EXC_ECALL_M}, 32'h1000_0040, 32'hDEAD_0001);
    csr_access(1'b0, MEPC_ADDR, 32'd0);
    csr_access(1'b0, MCAUSE_ADDR, 32'd0);
    csr_access(1'b0, MTVAL_ADDR, 32'd0);
    csr_access(1'b0, MSTATUS_ADDR, 32'd0);
    end_test();

    start_test("mret to user");
    csr_access(1'b1, MEPC_ADDR, 32'h2000_0100);
    csr_access(1'b1, MSTATUS_ADDR, 32'h0000_0080);  // mpp = U, mpie set
    expect_redirect(ref_csr[MEPC_ADDR], U_MODE);
    issue_mret();
    await_redirect("mret", 2);
    model_mret();
    check_priv("priv after mret", U_MODE, priv);
    foreach (CSR_LIST[i]) begin
      csr_access(1'b1, CSR_LIST[i], $urandom());
      csr_access(1'b0, CSR_LIST[i], 32'd0);
    end
    expect_redirect(ref_csr[MTVEC_ADDR] & ~32'h3, M_MODE);
    raise_trap(EXC_ECALL_U, 32'h2000_0104, 32'd0);
    await_redirect("user ecall", 2);
    model_trap({1'b0, EXC_ECALL_U}, 32'h2000_0104, 32'd0);
    check_priv("priv after ecall", M_MODE, priv);
    csr_access(1'b0, MSTATUS_ADDR, 32'd0);
    csr_access(1'b0, MSCRATCH_ADDR, 32'd0);
    end_test();

    start_test("vectored interrupt");
    csr_access(1'b1, MTVEC_ADDR, 32'h0000_0201);
    csr_access(1'b1, MIE_ADDR, 32'h0000_0880);      // mtie and meie
    csr_access(1'b1, MSTATUS_ADDR, 32'h0000_1808);
    base = ref_csr[MTVEC_ADDR] & ~32'h3;
    expect_redirect(base + 32'd4 * {1'b0, IRQ_M_TIMER}, M_MODE);
    irq_timer = 1'b1;
    await_redirect("timer irq", 0);
    model_trap({1'b1, IRQ_M_TIMER}, 32'd0, 32'd0);
    csr_access(1'b0, MCAUSE_ADDR, 32'd0);
    irq_timer = 1'b0;
    csr_access(1'b1, MSTATUS_ADDR, 32'h0000_1808);
    expect_redirect(base + 32'd4 * {1'b0, IRQ_M_EXT}, M_MODE);
    irq_timer = 1'b1;
    irq_ext = 1'b1;
    await_redirect("timer and ext irq", 0);
    model_trap({1'b1, IRQ_M_EXT}, 32'd0, 32'd0);
    csr_access(1'b0, MCAUSE_ADDR, 32'd0);
    irq_timer = 1'b0;
    irq_ext = 1'b0;
    end_test();

    start_test("counters");
    csr_access(1'b1, MCOUNTINHIBIT_ADDR, 32'd0);
    read_counter(MCYCLE_ADDR, c1, t1);
    repeat ($urandom_range(3, 12)) @(posedge CLK);
    read_counter(MCYCLE_ADDR, c2, t2);
    check_word("mcycle delta", t2 - t1, c2 - c1);
    read_counter(MINSTRET_ADDR, c1, t1);
    n_ret = 0;
    repeat ($urandom_range(10, 29)) begin
      inst_ret = $urandom_range(0, 1) == 1;
      if (inst_ret) n_ret++;
      @(posedge CLK);
      #1;
    end
    inst_ret = 1'b0;
    read_counter(MINSTRET_ADDR, c2, t2);
    check_word("minstret delta", n_ret, c2 - c1);
    csr_access(1'b1, MCOUNTINHIBIT_ADDR, 32'h0000_0001);  // Stop mcycle only
    read_counter(MCYCLE_ADDR, c1, t1);
    repeat (6) @(posedge CLK);
    read_counter(MCYCLE_ADDR, c2, t2);
    check_word("mcycle inhibited", c1, c2);
    end_test();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* priv_unit.f */
+incdir+source
+incdir+verif
source/priv_unit_pkg.sv
source/priv_perf_counters.sv
source/priv_csr_file.sv
source/priv_trap_fsm.sv
source/priv_unit_top.sv
verif/priv_unit_tb.sv

/* Makefile */
TOP := priv_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f priv_unit.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
